// ==== logic/csr_pkg.sv ====
package csr_pkg;

    // Command presented to the CSR stage each cycle
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_t;

    // Only user and machine mode exist
    typedef enum logic [1:0] {
        MODE_USER    = 2'b00,
        MODE_MACHINE = 2'b11
    } priv_mode_t;

    // [11:10] == 2'b11 marks read-only, [9:8] is the lowest mode allowed
    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] xlen_t;

    // Counters, user readable
    localparam csr_addr_t CSR_ADDR_CYCLE    = 12'hc00;
    localparam csr_addr_t CSR_ADDR_CYCLEH   = 12'hc80;

    // Machine information and trap setup
    localparam csr_addr_t CSR_ADDR_MHARTID  = 12'hf14;
    localparam csr_addr_t CSR_ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_ADDR_MISA     = 12'h301;
    localparam csr_addr_t CSR_ADDR_MIE      = 12'h304;
    localparam csr_addr_t CSR_ADDR_MTVEC    = 12'h305;

    // Machine trap handling
    localparam csr_addr_t CSR_ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_ADDR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_ADDR_MIP      = 12'h344;

    // Machine counter aliases
    localparam csr_addr_t CSR_ADDR_MCYCLE   = 12'hb00;
    localparam csr_addr_t CSR_ADDR_MCYCLEH  = 12'hb80;

    // MXL = 1 (RV32), extensions A, I and M
    localparam xlen_t MISA_VALUE = 32'h4000_1101;

    // Trap causes
    localparam xlen_t MCAUSE_ECALL_U       = 32'd8;
    localparam xlen_t MCAUSE_ECALL_M       = 32'd11;
    localparam xlen_t MCAUSE_MACHINE_TIMER = 32'h8000_0007;

endpackage

// ==== logic/csr_issue.sv ====
`timescale 1ns/100ps

module csr_issue
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  csr_cmd_t   csr_cmd,
    input  xlen_t      op1_data,
    input  xlen_t      imm_i,
    input  priv_mode_t mode,
    output csr_cmd_t   cmd,
    output csr_addr_t  addr,
    output logic       read_ok,
    output csr_cmd_t   wb_cmd,
    output csr_addr_t  wb_addr,
    output xlen_t      wb_op1,
    output logic       wb_write_ok
);

    logic access_ok;
    logic write_ok;

    // Flushed slot becomes a no-op on the read-only 0xfff
    assign cmd  = flush ? CSR_X : csr_cmd;
    assign addr = flush ? 12'hfff : imm_i[11:0];

    // Current mode must reach the address's minimum mode
    assign access_ok = mode >= addr[9:8];
    assign read_ok   = access_ok;
    // No writes into the 0xc00..0xfff read-only window
    assign write_ok  = access_ok && (addr[11:10] != 2'b11);

    // Write-back stage, control part
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_cmd      <= CSR_X;
            wb_write_ok <= 1'b0;
        end else begin
            wb_cmd      <= cmd;
            wb_write_ok <= write_ok;
        end
    end

    // Payload of the write-back stage
    always_ff @(posedge clk) begin
        wb_addr <= addr;
        wb_op1  <= op1_data;
    end

    // Squashed command must not commit a write one cycle later
    a_flush_no_write: assert property (
        @(posedge clk) disable iff (!rst_n) flush |=> !wb_write_ok
    );

endmodule

// ==== logic/csr_file.sv ====
`timescale 1ns/100ps

module csr_file
    import csr_pkg::*;
#(
    parameter xlen_t HART_ID = 32'h0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [63:0] cycle_count,
    input  logic [63:0] mtime,
    input  logic [63:0] mtimecmp,
    input  csr_addr_t   addr,
    input  logic        read_ok,
    input  csr_cmd_t    wb_cmd,
    input  csr_addr_t   wb_addr,
    input  xlen_t       wb_op1,
    input  logic        wb_write_ok,
    input  logic        trap_take,
    input  xlen_t       trap_cause,
    input  logic        trap_mret,
    input  priv_mode_t  mode,
    input  xlen_t       fetch_pc,
    output xlen_t       csr_rdata,
    output logic        mstatus_mie,
    output logic        mstatus_mpie,
    output priv_mode_t  mstatus_mpp,
    output logic        mie_mtie,
    output xlen_t       mtvec,
    output xlen_t       mepc
);

    xlen_t mscratch;
    xlen_t mcause;
    xlen_t rd_val;
    xlen_t wdata;
    logic  mtip;
    logic  wr_en;

    // Timer pending bit is live, never stored
    assign mtip = mtime >= mtimecmp;

    // Read multiplexer on the issue-stage address
    always_comb begin
        case (addr)
            CSR_ADDR_CYCLE, CSR_ADDR_MCYCLE:   rd_val = cycle_count[31:0];
            CSR_ADDR_CYCLEH, CSR_ADDR_MCYCLEH: rd_val = cycle_count[63:32];
            CSR_ADDR_MHARTID:  rd_val = HART_ID;
            CSR_ADDR_MSTATUS:  rd_val = {19'b0, mstatus_mpp, 3'b0, mstatus_mpie,
                                         3'b0, mstatus_mie, 3'b0};
            CSR_ADDR_MISA:     rd_val = MISA_VALUE;
            CSR_ADDR_MIE:      rd_val = {24'b0, mie_mtie, 7'b0};
            CSR_ADDR_MTVEC:    rd_val = mtvec;
            CSR_ADDR_MSCRATCH: rd_val = mscratch;
            CSR_ADDR_MEPC:     rd_val = mepc;
            CSR_ADDR_MCAUSE:   rd_val = mcause;
            CSR_ADDR_MIP:      rd_val = {24'b0, mtip, 7'b0};
            default:           rd_val = '0;
        endcase
    end

    // Old value is csr_rdata, read by the same command one cycle ago
    always_comb begin
        case (wb_cmd)
            CSR_W:   wdata = wb_op1;
            CSR_S:   wdata = csr_rdata | wb_op1;
            CSR_C:   wdata = csr_rdata & ~wb_op1;
            default: wdata = '0;
        endcase
    end

    assign wr_en = wb_write_ok && (wb_cmd == CSR_W || wb_cmd == CSR_S || wb_cmd == CSR_C);

    // Denied reads return zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csr_rdata <= '0;
        end else begin
            csr_rdata <= read_ok ? rd_val : '0;
        end
    end

    // Status, enable, vector and cause
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= MODE_MACHINE;
            mie_mtie     <= 1'b0;
            mtvec        <= '0;
            mcause       <= '0;
        end else begin
            if (wr_en) begin
                case (wb_addr)
                    CSR_ADDR_MSTATUS: begin
                        mstatus_mie  <= wdata[3];
                        mstatus_mpie <= wdata[7];
                        // Unsupported mpp values fall back to user
                        mstatus_mpp  <= (wdata[12:11] == 2'b11) ? MODE_MACHINE : MODE_USER;
                    end
                    CSR_ADDR_MIE:    mie_mtie <= wdata[7];
                    CSR_ADDR_MTVEC:  mtvec    <= wdata;
                    CSR_ADDR_MCAUSE: mcause   <= wdata;
                    default: begin
                    end
                endcase
            end
            // Trap side effects win over a software write
            if (trap_take) begin
                mcause       <= trap_cause;
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
                mstatus_mpp  <= mode;
            end else if (trap_mret) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpp  <= MODE_USER;
            end
        end
    end

    // Scratch and exception pc
    always_ff @(posedge clk) begin
        if (wr_en && wb_addr == CSR_ADDR_MSCRATCH) begin
            mscratch <= wdata;
        end
        // Interrupts save the fetch pc
        if (trap_take && trap_cause[31]) begin
            mepc <= fetch_pc;
        end else if (wr_en && wb_addr == CSR_ADDR_MEPC) begin
            mepc <= {wdata[31:2], 2'b00};
        end
    end

    a_trap_or_mret: assert property (
        @(posedge clk) disable iff (!rst_n) !(trap_take && trap_mret)
    );

endmodule

// ==== logic/csr_trap_unit.sv ====
`timescale 1ns/100ps

module csr_trap_unit
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  csr_cmd_t    cmd,
    input  logic [63:0] mtime,
    input  logic [63:0] mtimecmp,
    input  logic        mstatus_mie,
    input  logic        mstatus_mpie,
    input  priv_mode_t  mstatus_mpp,
    input  logic        mie_mtie,
    input  xlen_t       mtvec,
    input  xlen_t       mepc,
    input  logic        interrupt_ready,
    output priv_mode_t  mode,
    output logic        trap_take,
    output xlen_t       trap_cause,
    output logic        trap_mret,
    output csr_cmd_t    csr_cmd_out,
    output xlen_t       trap_vector,
    output logic        stall_may_interrupt
);

    logic  timer_pending;
    logic  take_irq;
    logic  is_ecall;
    xlen_t mtvec_base;
    xlen_t irq_vector;
    xlen_t ecall_cause;

    // Timer enabled and not masked in the current mode
    assign timer_pending = (mtime >= mtimecmp) && mie_mtie
                           && (mode == MODE_USER || (mode == MODE_MACHINE && mstatus_mie));
    // Early flag so the core can drain before the interrupt
    assign stall_may_interrupt = timer_pending;
    assign take_irq = timer_pending && interrupt_ready;

    // Direct mode jumps to mtvec, vectored to base + 4 * 7
    assign mtvec_base = {mtvec[31:2], 2'b00};
    assign irq_vector = (mtvec[1:0] == 2'b00) ? mtvec : mtvec_base + 32'd28;

    assign ecall_cause = (mode == MODE_USER) ? MCAUSE_ECALL_U : MCAUSE_ECALL_M;

    // Interrupt overrides the issued command
    assign is_ecall   = !take_irq && cmd == CSR_ECALL;
    assign trap_take  = take_irq || is_ecall;
    assign trap_cause = take_irq ? MCAUSE_MACHINE_TIMER : ecall_cause;
    assign trap_mret  = !take_irq && cmd == CSR_MRET;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode        <= MODE_MACHINE;
            csr_cmd_out <= CSR_X;
            trap_vector <= '0;
        end else begin
            csr_cmd_out <= take_irq ? CSR_ECALL : cmd;
            if (take_irq) begin
                trap_vector <= irq_vector;
                mode        <= MODE_MACHINE;
            end else if (is_ecall) begin
                // Every environment call lands in machine mode
                trap_vector <= mtvec_base;
                mode        <= MODE_MACHINE;
            end else if (trap_mret) begin
                trap_vector <= mepc;
                mode        <= mstatus_mpp;
            end
        end
    end

    a_mode_legal: assert property (
        @(posedge clk) disable iff (!rst_n) mode == MODE_USER || mode == MODE_MACHINE
    );

endmodule

// ==== logic/csr_stage.sv ====
`timescale 1ns/100ps

module csr_stage
    import csr_pkg::*;
#(
    parameter xlen_t HART_ID = 32'h0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [63:0] cycle_count,
    input  logic [63:0] mtime,
    input  logic [63:0] mtimecmp,
    input  logic        flush,
    input  csr_cmd_t    csr_cmd,
    input  xlen_t       op1_data,
    input  xlen_t       imm_i,
    input  logic        interrupt_ready,
    input  xlen_t       fetch_pc,
    output csr_cmd_t    csr_cmd_out,
    output xlen_t       csr_rdata,
    output xlen_t       trap_vector,
    output logic        stall_may_interrupt
);

    // Issue stage to register file
    csr_cmd_t   cmd;
    csr_addr_t  addr;
    logic       read_ok;
    csr_cmd_t   wb_cmd;
    csr_addr_t  wb_addr;
    xlen_t      wb_op1;
    logic       wb_write_ok;

    // Architectural state seen by the trap unit
    logic       mstatus_mie;
    logic       mstatus_mpie;
    priv_mode_t mstatus_mpp;
    logic       mie_mtie;
    xlen_t      mtvec;
    xlen_t      mepc;

    // Trap unit decisions
    priv_mode_t mode;
    logic       trap_take;
    xlen_t      trap_cause;
    logic       trap_mret;

    csr_issue i_csr_issue (
        .clk, .rst_n, .flush, .csr_cmd, .op1_data, .imm_i, .mode,
        .cmd, .addr, .read_ok, .wb_cmd, .wb_addr, .wb_op1, .wb_write_ok
    );

    csr_file #(
        .HART_ID(HART_ID)
    ) i_csr_file (
        .clk, .rst_n, .cycle_count, .mtime, .mtimecmp,
        .addr, .read_ok, .wb_cmd, .wb_addr, .wb_op1, .wb_write_ok,
        .trap_take, .trap_cause, .trap_mret, .mode, .fetch_pc,
        .csr_rdata, .mstatus_mie, .mstatus_mpie, .mstatus_mpp,
        .mie_mtie, .mtvec, .mepc
    );

    csr_trap_unit i_csr_trap_unit (
        .clk, .rst_n, .cmd, .mtime, .mtimecmp,
        .mstatus_mie, .mstatus_mpie, .mstatus_mpp, .mie_mtie, .mtvec, .mepc,
        .interrupt_ready, .mode, .trap_take, .trap_cause, .trap_mret,
        .csr_cmd_out, .trap_vector, .stall_may_interrupt
    );

endmodule

// ==== bench/tb_csr_stage.sv ====
`timescale 1ns/100ps

module tb_csr_stage
    import csr_pkg::*;
();

    localparam xlen_t       HART_ID       = 32'h0000_0005;
    // Words per stimulus line
    localparam int          FIELDS        = 13;
    localparam int          MAX_STEPS     = 64;
    localparam int          RESET_CYCLES  = 16;
    localparam int          IDLE_TIMEOUT  = 20;
    localparam logic [31:0] END_MARK      = 32'h0000_000f;

    logic        clk;
    logic        rst_n;
    logic [63:0] cycle_count;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        flush;
    csr_cmd_t    csr_cmd;
    xlen_t       op1_data;
    xlen_t       imm_i;
    logic        interrupt_ready;
    xlen_t       fetch_pc;
    csr_cmd_t    csr_cmd_out;
    xlen_t       csr_rdata;
    xlen_t       trap_vector;
    logic        stall_may_interrupt;

    logic [31:0] stim_mem [0:FIELDS*MAX_STEPS-1];
    // Counter value the DUT saw at the last edge
    logic [63:0] sampled_cycle;
    int          step;
    int          base;
    int          wait_count;
    logic        end_seen;

    csr_stage #(
        .HART_ID(HART_ID)
    ) i_csr_stage (
        .clk, .rst_n, .cycle_count, .mtime, .mtimecmp, .flush, .csr_cmd,
        .op1_data, .imm_i, .interrupt_ready, .fetch_pc,
        .csr_cmd_out, .csr_rdata, .trap_vector, .stall_may_interrupt
    );

    always #5 clk = ~clk;

    // One rising edge, then inputs move 1 ns later
    task automatic advance_cycle;
        @(posedge clk);
        sampled_cycle = cycle_count;
        #1;
        cycle_count = cycle_count + 64'd1;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t: step %0d, %s is %h, expected %h",
                     $time, step, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch, simulation stopped");
        end
    endtask

    // Inputs of one stimulus line
    task automatic apply_step(input int b);
        csr_cmd         = csr_cmd_t'(stim_mem[b][2:0]);
        op1_data        = stim_mem[b+1];
        imm_i           = stim_mem[b+2];
        flush           = stim_mem[b+3][0];
        interrupt_ready = stim_mem[b+4][0];
        mtime           = {32'h0, stim_mem[b+5]};
        mtimecmp        = {32'h0, stim_mem[b+6]};
        fetch_pc        = stim_mem[b+7];
    endtask

    // Mask bit picks which outputs count for this line
    task automatic check_step(input int b);
        logic [31:0] m;
        m = stim_mem[b+12];
        if (m[0]) check_value("csr_rdata", csr_rdata, stim_mem[b+8]);
        if (m[1]) check_value("trap_vector", trap_vector, stim_mem[b+9]);
        if (m[2]) check_value("csr_cmd_out", {29'b0, csr_cmd_out}, stim_mem[b+10]);
        if (m[3]) check_value("stall_may_interrupt", {31'b0, stall_may_interrupt},
                              stim_mem[b+11]);
        // Counter read compares with the driven counter itself
        if (m[4]) check_value("cycle read", csr_rdata, sampled_cycle[31:0]);
    endtask

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        cycle_count     = '0;
        mtime           = '0;
        mtimecmp        = '1;
        flush           = 1'b0;
        csr_cmd         = CSR_X;
        op1_data        = '0;
        imm_i           = '0;
        interrupt_ready = 1'b0;
        fetch_pc        = '0;
        sampled_cycle   = '0;
        end_seen        = 1'b0;
        $readmemh("bench/csr_stimulus.txt", stim_mem);

        for (int i = 0; i < RESET_CYCLES; i++) begin
            advance_cycle();
        end
        rst_n = 1'b1;

        // Outputs idle after reset, bounded wait
        wait_count = 0;
        while ((csr_cmd_out !== CSR_X || stall_may_interrupt !== 1'b0)
               && wait_count < IDLE_TIMEOUT) begin
            advance_cycle();
            wait_count++;
        end
        if (wait_count == IDLE_TIMEOUT) begin
            $display("Timeout: DUT outputs not idle %0d cycles after reset", IDLE_TIMEOUT);
            $display("TEST FAILED");
            $fatal(1, "reset wait timed out");
        end

        // Results of a line show one edge after it is applied
        for (step = 0; step < MAX_STEPS && !end_seen; step++) begin
            base = step * FIELDS;
            if (stim_mem[base] == END_MARK) begin
                end_seen = 1'b1;
            end else begin
                apply_step(base);
                advance_cycle();
                check_step(base);
            end
        end

        if (!end_seen) begin
            $display("Stimulus file has no end line within %0d steps", MAX_STEPS);
            $display("TEST FAILED");
            $fatal(1, "stimulus file incomplete");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== bench/csr_stimulus.txt ====
// cmd op1 imm flush irq_ready mtime mtimecmp fetch_pc exp_rdata exp_vector exp_cmd exp_stall mask
// mask: 1 rdata, 2 vector, 4 cmd_out, 8 stall, 10 rdata is cycle count; cmd f ends the run
0 00000000 301 0 0 00000000 ffffffff 00000000 40001101 00000000 0 0 0d
1 12345678 340 0 0 00000000 ffffffff 00000000 00000000 00000000 1 0 04
0 00000000 f14 0 0 00000000 ffffffff 00000000 00000005 00000000 0 0 01
2 0000f00f 340 0 0 00000000 ffffffff 00000000 12345678 00000000 0 0 01
1 00000100 305 0 0 00000000 ffffffff 00000000 00000000 00000000 0 0 01
3 00000fff 340 0 0 00000000 ffffffff 00000000 1234f67f 00000000 0 0 01
2 00000001 305 0 0 00000000 ffffffff 00000000 00000100 00000000 0 0 01
0 00000000 340 0 0 00000000 ffffffff 00000000 1234f000 00000000 0 0 01
3 00000001 305 0 0 00000000 ffffffff 00000000 00000101 00000000 0 0 01
1 00000203 341 0 0 00000000 ffffffff 00000000 00000000 00000000 0 0 00
0 00000000 305 0 0 00000000 ffffffff 00000000 00000100 00000000 0 0 01
// Machine ecall, then mret back to user
4 00000000 000 0 0 00000000 ffffffff 00000000 00000000 00000100 4 0 06
0 00000000 342 0 0 00000000 ffffffff 00000000 0000000b 00000000 0 0 01
1 00000000 300 0 0 00000000 ffffffff 00000000 00001800 00000000 0 0 01
0 00000000 341 0 0 00000000 ffffffff 00000000 00000200 00000000 0 0 01
5 00000000 000 0 0 00000000 ffffffff 00000000 00000000 00000200 5 0 06
// User mode access
0 00000000 340 0 0 00000000 ffffffff 00000000 00000000 00000000 0 0 01
1 deadbeef 340 0 0 00000000 ffffffff 00000000 00000000 00000000 0 0 01
0 00000000 c00 0 0 00000000 ffffffff 00000000 00000000 00000000 0 0 10
0 00000000 b00 0 0 00000000 ffffffff 00000000 00000000 00000000 0 0 01
4 00000000 000 0 0 00000000 ffffffff 00000000 00000000 00000100 4 0 06
0 00000000 342 0 0 00000000 ffffffff 00000000 00000008 00000000 0 0 01
0 00000000 340 0 0 00000000 ffffffff 00000000 1234f000 00000000 0 0 01
// Timer interrupt with vectored mtvec
1 00000201 305 0 0 00000000 ffffffff 00000000 00000100 00000000 0 0 01
1 00000080 304 0 0 00000000 ffffffff 00000000 00000000 00000000 0 0 01
1 00000008 300 0 0 00000000 ffffffff 00000000 00000000 00000000 0 0 01
0 00000000 344 0 0 00000000 ffffffff 00000000 00000000 00000000 0 0 09
0 00000000 344 0 0 00000100 00000080 00000000 00000080 00000000 0 1 09
0 00000000 000 0 1 00000100 00000080 00001234 00000000 0000021c 4 0 0e
0 00000000 341 0 0 00000000 ffffffff 00000000 00001234 00000000 0 0 01
0 00000000 342 0 0 00000000 ffffffff 00000000 80000007 00000000 0 0 01
0 00000000 300 0 0 00000000 ffffffff 00000000 00001880 00000000 0 0 01
// Flushed write
1 0badf00d 340 1 0 00000000 ffffffff 00000000 00000000 00000000 0 0 05
0 00000000 c80 0 0 00000000 ffffffff 00000000 00000000 00000000 0 0 01
0 00000000 340 0 0 00000000 ffffffff 00000000 1234f000 00000000 0 0 01
f 00000000 000 0 0 00000000 00000000 00000000 00000000 00000000 0 0 00

// ==== tb.f ====
logic/csr_pkg.sv
logic/csr_issue.sv
logic/csr_file.sv
logic/csr_trap_unit.sv
logic/csr_stage.sv
bench/tb_csr_stage.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = tb_csr_stage
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TEST OK" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
